// ==== logic/alu_defines.svh ====
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// Operand width that the opcode set is built around
`define DATA_WIDTH 8

// MUL returns the full double-width product
`define RESULT_WIDTH (2 * `DATA_WIDTH)

// ************************************************************
// APB register map as byte offsets
// ************************************************************

`define REG_OPA    8'h00
`define REG_OPB    8'h04
`define REG_CTRL   8'h08 // Writing an opcode here launches the operation
`define REG_STATUS 8'h0C // Bit 0 busy, bit 1 zero, bit 2 carry
`define REG_RESULT 8'h10

`endif

// ==== logic/apbPkg.sv ====
`default_nettype none

package apbPkg;

	localparam int APB_ADDR_WIDTH = 8;
	localparam int APB_DATA_WIDTH = 32;

	// Driven by the requester for both setup and access phases
	typedef struct packed
	{
		logic psel;
		logic penable;
		logic pwrite;
		logic [APB_ADDR_WIDTH-1:0] paddr;
		logic [APB_DATA_WIDTH-1:0] pwdata;
	} apbReq_t;

	// Returned by the slave and only meaningful in the access phase
	typedef struct packed
	{
		logic [APB_DATA_WIDTH-1:0] prdata;
		logic pready;
		logic pslverr;
	} apbRsp_t;

endpackage

`default_nettype wire

// ==== logic/aluPkg.sv ====
`default_nettype none

`include "alu_defines.svh"

package aluPkg;

	// Codes above MUL are illegal
	typedef enum logic [3:0]
	{
		ADD = 4'h0,
		SUB = 4'h1,
		AND = 4'h2,
		OR  = 4'h3,
		XOR = 4'h4,
		NOT = 4'h5,
		SHL = 4'h6,
		SHR = 4'h7,
		INC = 4'h8,
		DEC = 4'h9,
		MUL = 4'hA
	} aluOp_e;

	// One operation handed to both execution units
	typedef struct packed
	{
		logic start; // Single-cycle pulse
		aluOp_e op;
		logic [`DATA_WIDTH-1:0] opA;
		logic [`DATA_WIDTH-1:0] opB;
	} aluIssue_t;

	typedef struct packed
	{
		logic valid;
		logic [`RESULT_WIDTH-1:0] value;
		logic carry; // Carry, borrow or shifted-out bit
	} aluResult_t;

	function automatic logic isLegalOp(input logic [3:0] code);
		return code <= MUL;
	endfunction

endpackage

`default_nettype wire

// ==== logic/aluApbRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module aluApbRegs
(
	input logic iClk,
	input logic rstN,
	input apbPkg::apbReq_t apbReq,
	output apbPkg::apbRsp_t apbRsp,
	output aluPkg::aluIssue_t issue,
	input aluPkg::aluResult_t result,
	input logic zero,
	input logic done
);
	import apbPkg::*;
	import aluPkg::*;

	logic accessPhase;
	logic wrAccess;
	logic addrMapped;
	logic ctrlWrite;
	logic opLegal;
	logic ctrlAccept;
	logic errAccess;
	logic [3:0] wrCode;
	logic [`DATA_WIDTH-1:0] opA;
	logic [`DATA_WIDTH-1:0] opB;
	aluOp_e lastOp;
	logic busy;
	logic startQ;
	logic [APB_DATA_WIDTH-1:0] readData;

	// ************************************************************
	// Access decode
	// ************************************************************

	assign accessPhase = apbReq.psel && apbReq.penable;
	assign wrAccess = accessPhase && apbReq.pwrite;
	assign wrCode = apbReq.pwdata[3:0];
	assign opLegal = isLegalOp(wrCode);

	always_comb
	begin
		case (apbReq.paddr)
			`REG_OPA, `REG_OPB, `REG_CTRL, `REG_STATUS, `REG_RESULT: addrMapped = 1'b1;
			default: addrMapped = 1'b0;
		endcase
	end

	assign ctrlWrite = wrAccess && apbReq.paddr == `REG_CTRL;
	assign ctrlAccept = ctrlWrite && !busy && opLegal;

	// Bad address, busy unit or unknown opcode
	assign errAccess = accessPhase && (!addrMapped || (ctrlWrite && !ctrlAccept));

	// ************************************************************
	// Register state
	// ************************************************************

	always_ff @(posedge iClk)
	begin
		if (!rstN)
		begin
			opA <= '0;
			opB <= '0;
			lastOp <= ADD;
		end
		else
		begin
			if (wrAccess && apbReq.paddr == `REG_OPA)
				opA <= apbReq.pwdata[`DATA_WIDTH-1:0];
			if (wrAccess && apbReq.paddr == `REG_OPB)
				opB <= apbReq.pwdata[`DATA_WIDTH-1:0];
			if (ctrlAccept)
				lastOp <= aluOp_e'(wrCode);
		end
	end

	// Busy spans from the accepted write up to the collector's done
	always_ff @(posedge iClk)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			startQ <= 1'b0;
		end
		else
		begin
			startQ <= ctrlAccept;
			if (ctrlAccept)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;
		end
	end

	assign issue = '{start: startQ, op: lastOp, opA: opA, opB: opB};

	always_comb
	begin
		readData = '0;
		case (apbReq.paddr)
			`REG_OPA: readData[`DATA_WIDTH-1:0] = opA;
			`REG_OPB: readData[`DATA_WIDTH-1:0] = opB;
			`REG_CTRL: readData[3:0] = lastOp;
			`REG_STATUS: readData[2:0] = {result.carry, zero, busy};
			`REG_RESULT: readData[`RESULT_WIDTH-1:0] = result.value;
			default: readData = '0;
		endcase
	end

	// No wait states
	assign apbRsp = '{
		prdata: (accessPhase && !apbReq.pwrite) ? readData : '0,
		pready: 1'b1,
		pslverr: errAccess
	};

	// Each completion closes the operation in flight and never lands on a launch
	assert property (@(posedge iClk) disable iff (!rstN) done |-> busy && !issue.start);

endmodule

`default_nettype wire

// ==== logic/aluLogicUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module aluLogicUnit
(
	input logic iClk,
	input logic rstN,
	input aluPkg::aluIssue_t issue,
	output aluPkg::aluResult_t result
);
	import aluPkg::*;

	localparam int PAD = `RESULT_WIDTH - `DATA_WIDTH;

	logic startMine;
	logic [`DATA_WIDTH:0] wide; // Top bit is the carry
	logic [`DATA_WIDTH-1:0] resValue;
	logic resCarry;
	logic resValid;

	assign startMine = issue.start && issue.op != MUL;

	always_comb
	begin
		case (issue.op)
			ADD: wide = {1'b0, issue.opA} + {1'b0, issue.opB};
			SUB: wide = {1'b0, issue.opA} - {1'b0, issue.opB}; // Borrow shows up on top
			AND: wide = {1'b0, issue.opA & issue.opB};
			OR:  wide = {1'b0, issue.opA | issue.opB};
			XOR: wide = {1'b0, issue.opA ^ issue.opB};
			NOT: wide = {1'b0, ~issue.opA};
			SHL: wide = {issue.opA, 1'b0};
			SHR: wide = {issue.opA[0], 1'b0, issue.opA[`DATA_WIDTH-1:1]};
			INC: wide = {1'b0, issue.opA} + 1'b1;
			DEC: wide = {1'b0, issue.opA} - 1'b1;
			default: wide = '0;
		endcase
	end

	always_ff @(posedge iClk)
	begin
		if (!rstN)
			resValid <= 1'b0;
		else
			resValid <= startMine;
	end

	always_ff @(posedge iClk)
	begin
		if (startMine)
		begin
			resValue <= wide[`DATA_WIDTH-1:0];
			resCarry <= wide[`DATA_WIDTH];
		end
	end

	assign result = '{
		valid: resValid,
		value: {{PAD{1'b0}}, resValue},
		carry: resCarry
	};

	// One-cycle answer to each of its own launches
	assert property (@(posedge iClk) disable iff (!rstN)
		startMine |=> result.valid ##1 !result.valid);

endmodule

`default_nettype wire

// ==== logic/shiftAddMultiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module shiftAddMultiplier
(
	input logic iClk,
	input logic rstN,
	input aluPkg::aluIssue_t issue,
	output aluPkg::aluResult_t result
);
	import aluPkg::*;

	localparam int PAD = `RESULT_WIDTH - `DATA_WIDTH;

	logic startMul;
	logic running;
	logic resValid;
	logic [2:0] count;
	logic [`RESULT_WIDTH-1:0] opAWide;
	logic [`RESULT_WIDTH-1:0] acc;
	logic [`RESULT_WIDTH-1:0] mcand;
	logic [`RESULT_WIDTH-1:0] addend;
	logic [`DATA_WIDTH-1:0] mplier;

	assign startMul = issue.start && issue.op == MUL;
	assign opAWide = {{PAD{1'b0}}, issue.opA};
	assign addend = mplier[0] ? mcand : '0;

	// ************************************************************
	// Step control
	// ************************************************************

	// The load performs step 0, so counts 1..7 finish the other seven
	always_ff @(posedge iClk)
	begin
		if (!rstN)
		begin
			running <= 1'b0;
			count <= '0;
			resValid <= 1'b0;
		end
		else
		begin
			resValid <= 1'b0;
			if (startMul)
			begin
				running <= 1'b1;
				count <= 3'd1;
			end
			else if (running)
			begin
				count <= count + 3'd1;
				if (count == 3'd7)
				begin
					running <= 1'b0;
					resValid <= 1'b1;
				end
			end
		end
	end

	// ************************************************************
	// Shift-and-add datapath
	// ************************************************************

	always_ff @(posedge iClk)
	begin
		if (startMul)
		begin
			acc <= issue.opB[0] ? opAWide : '0;
			mcand <= opAWide << 1;
			mplier <= issue.opB >> 1;
		end
		else if (running)
		begin
			acc <= acc + addend;
			mcand <= mcand << 1; // Next bit weight
			mplier <= mplier >> 1;
		end
	end

	// Acc holds the product until the next load
	assign result = '{valid: resValid, value: acc, carry: 1'b0};

	assert property (@(posedge iClk) disable iff (!rstN) running |-> !issue.start);

endmodule

`default_nettype wire

// ==== logic/resultCollector.sv ====
`timescale 1ns/1ps
`default_nettype none

module resultCollector
(
	input logic iClk,
	input logic rstN,
	input aluPkg::aluResult_t logicRes,
	input aluPkg::aluResult_t mulRes,
	output aluPkg::aluResult_t stored,
	output logic zero,
	output logic done
);

	// Stored.valid stays set once any result has been captured
	always_ff @(posedge iClk)
	begin
		if (!rstN)
		begin
			stored <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= logicRes.valid || mulRes.valid;
			if (logicRes.valid)
				stored <= logicRes;
			else if (mulRes.valid)
				stored <= mulRes;
		end
	end

	// Nothing held yet reads as not zero
	assign zero = stored.valid && stored.value == '0;

	// Only one unit answers any given launch
	assert property (@(posedge iClk) disable iff (!rstN) !(logicRes.valid && mulRes.valid));

endmodule

`default_nettype wire

// ==== logic/aluApbTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluApbTop
(
	input logic iClk,
	input logic rstN,
	input apbPkg::apbReq_t apbReq,
	output apbPkg::apbRsp_t apbRsp
);
	import aluPkg::*;

	aluIssue_t issue;
	aluResult_t logicRes;
	aluResult_t mulRes;
	aluResult_t stored;
	logic zero;
	logic done;

	aluApbRegs u_aluApbRegs
	(
		.iClk(iClk),
		.rstN(rstN),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.issue(issue),
		.result(stored),
		.zero(zero),
		.done(done)
	);

	// Both units see every launch and pick out their own opcodes
	aluLogicUnit u_aluLogicUnit
	(
		.iClk(iClk),
		.rstN(rstN),
		.issue(issue),
		.result(logicRes)
	);

	shiftAddMultiplier u_shiftAddMultiplier
	(
		.iClk(iClk),
		.rstN(rstN),
		.issue(issue),
		.result(mulRes)
	);

	resultCollector u_resultCollector
	(
		.iClk(iClk),
		.rstN(rstN),
		.logicRes(logicRes),
		.mulRes(mulRes),
		.stored(stored),
		.zero(zero),
		.done(done)
	);

endmodule

`default_nettype wire

// ==== tb/aluApbTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module aluApbTb;
	import apbPkg::*;
	import aluPkg::*;

	localparam int PAIRS_PER_OP = 30;
	localparam int MUL_RANDOM = 16;
	localparam int OPS_PLANNED = 10 * PAIRS_PER_OP + MUL_RANDOM + 5 + 4;
	localparam int CYCLE_LIMIT = 40 * OPS_PLANNED + 200;
	localparam int MAX_POLLS = 12;

	logic iClk = 1'b0;
	logic rstN;
	apbReq_t apbReq;
	apbRsp_t apbRsp;
	logic accessNow;
	int cycleCnt = 0;
	int errCount = 0;
	int passCount = 0;
	int failCount = 0;

	// Expectation for the access phase currently on the bus
	logic expErr;
	logic [31:0] expData;
	logic [31:0] expMask;

	// Reference model state
	int ctrlEdge = -1000; // Cycle count of the last accepted control write
	int busyEdges = 0;
	logic [15:0] mdlValue = '0;
	logic mdlCarry = 1'b0;
	logic mdlZero = 1'b0;
	aluOp_e mdlOp = ADD;
	logic [7:0] mdlOpA = '0;
	logic [7:0] mdlOpB = '0;

	aluApbTop u_aluApbTop
	(
		.iClk(iClk),
		.rstN(rstN),
		.apbReq(apbReq),
		.apbRsp(apbRsp)
	);

	always #2 iClk = ~iClk;

	always @(posedge iClk)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= CYCLE_LIMIT)
		begin
			$display("Run stopped after %0d cycles without finishing", CYCLE_LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic void mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		errCount++;
		$display("[ERROR] t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp, act);
	endfunction

	// ************************************************************
	// Checks on every completed access
	// ************************************************************

	assign accessNow = apbReq.psel && apbReq.penable;

	// Sampled mid-cycle so DUT outputs have settled
	assert property (@(negedge iClk) disable iff (!rstN) accessNow |-> apbRsp.pslverr == expErr)
		else mismatch("pslverr", {31'b0, expErr}, {31'b0, apbRsp.pslverr});

	assert property (@(negedge iClk) disable iff (!rstN)
		(accessNow && !apbReq.pwrite) |-> (apbRsp.prdata & expMask) == expData)
		else mismatch($sformatf("prdata@0x%02h", apbReq.paddr), expData,
			apbRsp.prdata & expMask);

	assert property (@(negedge iClk) disable iff (!rstN) accessNow |-> apbRsp.pready)
		else mismatch("pready", 32'h1, {31'b0, apbRsp.pready});

	function automatic void modelOp(input aluOp_e op, input int a, input int b,
		output int value, output logic carry);
		carry = 1'b0;
		case (op)
			ADD:
			begin
				value = (a + b) % 256;
				carry = a + b > 255;
			end
			SUB:
			begin
				value = (a - b + 256) % 256;
				carry = a < b; // Borrow
			end
			AND: value = a & b;
			OR: value = a | b;
			XOR: value = a ^ b;
			NOT: value = 255 - a;
			SHL:
			begin
				value = (a * 2) % 256;
				carry = a >= 128;
			end
			SHR:
			begin
				value = a / 2;
				carry = a % 2 == 1;
			end
			INC:
			begin
				value = (a + 1) % 256;
				carry = a == 255;
			end
			DEC:
			begin
				value = (a + 255) % 256;
				carry = a == 0;
			end
			default: value = a * b;
		endcase
	endfunction

	// ************************************************************
	// APB driver tasks enter and leave 1 ns after a rising edge
	// ************************************************************

	task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, input logic err);
		apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(posedge iClk);
		#1;
		expErr = err;
		apbReq.penable = 1'b1;
		@(posedge iClk);
		#1;
		apbReq = '0;
		expErr = 1'b0;
	endtask

	task automatic apbRead(input logic [7:0] addr, input logic [31:0] expD, input logic err,
		output logic [31:0] data);
		apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
		@(posedge iClk);
		#1;
		expData = expD;
		expMask = 32'hFFFF_FFFF;
		if (addr == `REG_STATUS && !err)
		begin
			if (cycleCnt - ctrlEdge < busyEdges)
			begin
				expData = 32'h1; // Flags still belong to the previous result
				expMask = 32'hFFFF_FFF9;
			end
			else
				expData = {29'b0, mdlCarry, mdlZero, 1'b0};
		end
		expErr = err;
		apbReq.penable = 1'b1;
		@(negedge iClk);
		data = apbRsp.prdata;
		@(posedge iClk);
		#1;
		apbReq = '0;
		expErr = 1'b0;
	endtask

	task automatic readExpect(input logic [7:0] addr, input logic [31:0] expD);
		logic [31:0] rd;
		apbRead(addr, expD, 1'b0, rd);
	endtask

	task automatic issueOp(input aluOp_e op, input logic [7:0] a, input logic [7:0] b);
		int value;
		logic carry;
		apbWrite(`REG_OPA, {24'b0, a}, 1'b0);
		apbWrite(`REG_OPB, {24'b0, b}, 1'b0);
		modelOp(op, int'(a), int'(b), value, carry);
		apbWrite(`REG_CTRL, {28'b0, op}, 1'b0);
		ctrlEdge = cycleCnt;
		busyEdges = (op == MUL) ? 10 : 3; // Valid, done, then busy drops
		mdlValue = 16'(value);
		mdlCarry = carry;
		mdlZero = value == 0;
		mdlOp = op;
		mdlOpA = a;
		mdlOpB = b;
	endtask

	task automatic waitIdle();
		logic [31:0] rd;
		int polls;
		polls = 0;
		rd = 32'h1;
		while (rd[0] && polls < MAX_POLLS)
		begin
			apbRead(`REG_STATUS, 32'h0, 1'b0, rd);
			polls++;
		end
		if (rd[0])
		begin
			errCount++;
			$display("Unit still busy after %0d status reads at t=%0t", polls, $time);
		end
	endtask

	task automatic runOp(input aluOp_e op, input logic [7:0] a, input logic [7:0] b);
		issueOp(op, a, b);
		waitIdle();
		readExpect(`REG_RESULT, {16'b0, mdlValue});
	endtask

	task automatic endTest(input string name, input int errsBefore);
		if (errCount == errsBefore)
		begin
			passCount++;
			$display("test %s: ok", name);
		end
		else
		begin
			failCount++;
			$display("test %s: %0d errors", name, errCount - errsBefore);
		end
	endtask

	initial
	begin
		int startErrs;
		logic [7:0] x;
		logic [7:0] a;
		logic [31:0] rd;
		aluOp_e op;
		apbReq = '0;
		expErr = 1'b0;
		expData = '0;
		expMask = '0;
		rstN = 1'b0;
		void'($urandom(32'h8851_5e09));
		repeat (5) @(posedge iClk);
		#1;
		rstN = 1'b1;

		startErrs = errCount;
		readExpect(`REG_OPA, 32'h0);
		readExpect(`REG_OPB, 32'h0);
		readExpect(`REG_CTRL, 32'h0);
		readExpect(`REG_STATUS, 32'h0);
		readExpect(`REG_RESULT, 32'h0);
		endTest("reset", startErrs);

		for (int k = 0; k < 10; k++)
		begin
			startErrs = errCount;
			op = aluOp_e'(k);
			for (int n = 0; n < PAIRS_PER_OP; n++)
			begin
				a = 8'($urandom());
				if (n == 0)
					a = (op == DEC) ? 8'h00 : 8'hFF; // Reaches the carry and borrow corners
				runOp(op, a, 8'($urandom()));
			end
			endTest(op.name(), startErrs);
		end

		startErrs = errCount;
		for (int n = 0; n < MUL_RANDOM; n++)
			runOp(MUL, 8'($urandom()), 8'($urandom()));
		x = 8'($urandom());
		runOp(MUL, 8'd0, x);
		runOp(MUL, x, 8'd0);
		runOp(MUL, 8'd255, 8'd255);
		runOp(MUL, 8'd1, x);
		runOp(MUL, x, 8'd1);
		endTest("MUL", startErrs);

		// A launch while the multiplier runs must bounce off
		startErrs = errCount;
		issueOp(MUL, 8'($urandom()), 8'($urandom()));
		apbWrite(`REG_CTRL, {28'b0, ADD}, 1'b1);
		waitIdle();
		readExpect(`REG_RESULT, {16'b0, mdlValue});
		readExpect(`REG_CTRL, {28'b0, MUL});
		endTest("busyReject", startErrs);

		startErrs = errCount;
		for (int code = 11; code < 16; code++)
			apbWrite(`REG_CTRL, 32'(code), 1'b1);
		apbWrite(8'h14, $urandom(), 1'b1);
		apbWrite(8'h01, $urandom(), 1'b1);
		apbRead(8'h20, 32'h0, 1'b1, rd);
		readExpect(`REG_CTRL, {28'b0, mdlOp});
		readExpect(`REG_OPA, {24'b0, mdlOpA});
		readExpect(`REG_OPB, {24'b0, mdlOpB});
		readExpect(`REG_STATUS, 32'h0);
		readExpect(`REG_RESULT, {16'b0, mdlValue});
		endTest("badAccess", startErrs);

		startErrs = errCount;
		x = 8'($urandom());
		runOp(SUB, x, x);
		readExpect(`REG_STATUS, 32'h2);
		runOp(MUL, 8'd0, x);
		readExpect(`REG_STATUS, 32'h2);
		runOp(ADD, 8'd1, 8'd2);
		readExpect(`REG_STATUS, 32'h0);
		endTest("zeroFlag", startErrs);

		$display("tests passed %0d failed %0d", passCount, failCount);
		if (failCount == 0 && errCount == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+logic
logic/apbPkg.sv
logic/aluPkg.sv
logic/aluApbRegs.sv
logic/aluLogicUnit.sv
logic/shiftAddMultiplier.sv
logic/resultCollector.sv
logic/aluApbTop.sv
tb/aluApbTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 --top-module aluApbTb -f sim.f -o aluApbSim

out=$(./obj_dir/aluApbSim)
echo "$out"

# Exit status comes from the search for the pass line
echo "$out" | grep -Fqx '>>> PASS'
